// File: files.f
+incdir+testbench
src/isa_pkg.sv
src/pipe_pkg.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/core_top.sv
testbench/tb_core_top.sv

// File: Makefile
TOP = tb_core_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f files.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Test FAILED" sim.log; then echo "Simulation failed."; exit 1; fi
	@grep -q "Test OK" sim.log || (echo "Simulation ended without a result."; exit 1)

lint:
	verilator --lint-only -Wall --top-module core_top \
		src/isa_pkg.sv src/pipe_pkg.sv src/decode_stage.sv \
		src/execute_stage.sv src/result_stage.sv src/core_top.sv

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_checks.svh
////////////////////
// Commit records and compare tasks

function automatic commit_t write_commit(input reg_addr_t rd, input word_t data);
    commit_t c;
    c       = '0;
    c.valid = 1'b1;
    c.wr_en = 1'b1;
    c.rd    = rd;
    c.data  = data;
    return c;
endfunction

// A commit without a register write. Its rd is the raw field of the word.
function automatic commit_t quiet_commit(input word_t inst, input logic exc,
                                         input exc_cause_t cause);
    commit_t c;
    c       = '0;
    c.valid = 1'b1;
    c.exc   = exc;
    c.cause = cause;
    c.rd    = inst[4:0];
    return c;
endfunction

task automatic check_commit(input commit_t got, input commit_t exp);
    if (got !== exp) begin
        $display("FAILED at %0t: commit exc=%0b cause=%h wr_en=%0b rd=%0d data=%h",
                 $time, got.exc, got.cause, got.wr_en, got.rd, got.data);
        $display("    expected exc=%0b cause=%h wr_en=%0b rd=%0d data=%h",
                 exp.exc, exp.cause, exp.wr_en, exp.rd, exp.data);
        abort_run();
    end
endtask

task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
        $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        abort_run();
    end
endtask

task automatic drain();
    while (expected.size() != 0) begin
        @(negedge clk);
    end
endtask

////////////////////
// Instruction drivers

task automatic run_rr(input opcode17_t op, input reg_addr_t rd, input reg_addr_t rj,
                      input reg_addr_t rk);
    issue({op, rk, rj, rd}, write_commit(rd, reference_result(op, model[rj], model[rk])));
endtask

task automatic run_shift_imm(input opcode17_t op, input reg_addr_t rd, input reg_addr_t rj,
                             input logic [4:0] shamt);
    issue({op, shamt, rj, rd}, write_commit(rd, reference_result(op, model[rj], {27'b0, shamt})));
endtask

task automatic run_imm(input opcode10_t op, input reg_addr_t rd, input reg_addr_t rj,
                       input imm12_t imm);
    word_t sext;
    word_t zext;
    word_t res;
    sext = {{20{imm[11]}}, imm};
    zext = {20'b0, imm};  // Logic immediates are not sign extended.
    case (op)
        OP10_SLTI:  res = reference_result(OP17_SLT, model[rj], sext);
        OP10_SLTUI: res = reference_result(OP17_SLTU, model[rj], sext);
        OP10_ADDIW: res = reference_result(OP17_ADDW, model[rj], sext);
        OP10_ANDI:  res = reference_result(OP17_AND, model[rj], zext);
        OP10_ORI:   res = reference_result(OP17_OR, model[rj], zext);
        default:    res = reference_result(OP17_XOR, model[rj], zext);
    endcase
    issue({op, imm, rj, rd}, write_commit(rd, res));
endtask

task automatic run_upper(input opcode7_t op, input reg_addr_t rd, input imm20_t imm);
    word_t res;
    res = {imm, 12'b0};
    if (op == OP7_PCADDU12I) begin
        res = res + cur_pc;
    end
    issue({op, imm, rd}, write_commit(rd, res));
endtask

task automatic load_reg(input reg_addr_t rd, input word_t value);
    run_upper(OP7_LU12IW, rd, value[31:12]);
    run_imm(OP10_ORI, rd, rd, value[11:0]);
endtask

////////////////////
// Directed tests

task automatic test_reset_state();
    repeat (3) begin
        @(negedge clk);
        if (commit_o.valid) begin
            $display("commit_o.valid went high before any instruction was issued.");
            abort_run();
        end
    end
    run_rr(OP17_ADDW, 5'd1, 5'd0, 5'd0);
    run_rr(OP17_ADDW, 5'd2, 5'd5, 5'd6);  // Untouched registers read zero.
    drain();
endtask

task automatic test_reg_ops();
    opcode17_t ops [$] = '{OP17_ADDW, OP17_SUBW, OP17_SLT, OP17_SLTU, OP17_NOR, OP17_AND,
                           OP17_OR, OP17_XOR, OP17_SLLW, OP17_SRLW, OP17_SRAW};
    load_reg(5'd1, word_t'($random(seed)) | 32'h8000_0000);
    load_reg(5'd2, word_t'($random(seed)) & 32'h7fff_ffff);
    load_reg(5'd3, word_t'($random(seed)));
    foreach (ops[i]) begin
        run_rr(ops[i], 5'd10, 5'd1, 5'd2);
        run_rr(ops[i], 5'd11, 5'd2, 5'd1);
        run_rr(ops[i], 5'd12, 5'd3, 5'd1);
    end
    drain();
endtask

task automatic test_imm_ops();
    opcode10_t  ops [$] = '{OP10_SLTI, OP10_SLTUI, OP10_ADDIW, OP10_ANDI, OP10_ORI, OP10_XORI};
    imm12_t     imm;
    logic [4:0] shamt;
    load_reg(5'd4, word_t'($random(seed)));
    load_reg(5'd5, word_t'($random(seed)) | 32'h8000_0000);
    foreach (ops[i]) begin
        imm = imm12_t'($random(seed)) | 12'h800;
        run_imm(ops[i], 5'd13, 5'd4, imm);
        run_imm(ops[i], 5'd14, 5'd5, imm & 12'h7ff);
    end
    repeat (4) begin
        shamt = 5'($random(seed));
        run_shift_imm(OP17_SLLIW, 5'd15, 5'd5, shamt);
        run_shift_imm(OP17_SRLIW, 5'd16, 5'd5, shamt);
        run_shift_imm(OP17_SRAIW, 5'd17, 5'd5, shamt);
    end
    run_upper(OP7_PCADDU12I, 5'd18, imm20_t'($random(seed)));
    drain();
endtask

// Each step reads the rd of the step right before it.
task automatic test_bypass_chain();
    load_reg(5'd20, word_t'($random(seed)));
    run_rr(OP17_ADDW, 5'd21, 5'd20, 5'd20);
    run_rr(OP17_SUBW, 5'd22, 5'd21, 5'd20);
    run_rr(OP17_XOR, 5'd23, 5'd22, 5'd21);
    run_imm(OP10_ADDIW, 5'd24, 5'd23, 12'hf9c);
    run_shift_imm(OP17_SRAIW, 5'd25, 5'd24, 5'd7);
    run_rr(OP17_SLLW, 5'd26, 5'd25, 5'd22);
    run_imm(OP10_ORI, 5'd0, 5'd26, 12'h5a5);  // Reported, but r0 keeps zero.
    run_rr(OP17_OR, 5'd27, 5'd0, 5'd0);
    run_rr(OP17_ADDW, 5'd28, 5'd0, 5'd26);
    drain();
endtask

task automatic test_exceptions();
    word_t     inst;
    reg_addr_t r;
    inst = {OP17_BREAK, 10'($random(seed)), 5'd21};
    issue(inst, quiet_commit(inst, 1'b1, EXC_BRK));
    inst = {OP17_SYSCALL, 10'($random(seed)), 5'd22};
    issue(inst, quiet_commit(inst, 1'b1, EXC_SYS));
    // A top field of all ones matches no opcode of any width.
    inst = {7'h7f, 20'($random(seed)), 5'd23};
    issue(inst, quiet_commit(inst, 1'b1, EXC_INE));
    inst = '0;
    issue(inst, quiet_commit(inst, 1'b0, '0));
    run_rr(OP17_OR, 5'd29, 5'd21, 5'd0);
    run_rr(OP17_OR, 5'd30, 5'd22, 5'd23);
    drain();
    @(negedge clk);
    for (int i = 0; i < REG_COUNT; i++) begin
        r = reg_addr_t'(i);
        check_word(i_dut.u_result.regs[r], model[r], $sformatf("register r%0d", i));
    end
endtask

// File: testbench/tb_core_top.sv
`timescale 1ns/10ps

module tb_core_top;

    import isa_pkg::*;
    import pipe_pkg::*;

    logic    clk;
    logic    reset_i;
    logic    inst_en_i;
    word_t   pc_i;
    word_t   inst_i;
    commit_t commit_o;

    integer  seed;
    int      issued;
    word_t   cur_pc;
    word_t   model [REG_COUNT];   // Reference register file.
    commit_t expected [$];        // Commits still in flight with the oldest first.

    core_top i_dut (
        .clk       (clk),
        .reset_i   (reset_i),
        .inst_en_i (inst_en_i),
        .pc_i      (pc_i),
        .inst_i    (inst_i),
        .commit_o  (commit_o)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    `include "tb_checks.svh"

    ////////////////////
    // Reference model

    function automatic word_t reference_result(input opcode17_t op, input word_t a,
                                               input word_t b);
        word_t r;
        case (op)
            OP17_ADDW: r = a + b;
            OP17_SUBW: r = a - b;
            OP17_SLT:  r = {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};  // Sign decides first.
            OP17_SLTU: r = {31'b0, a < b};
            OP17_NOR:  r = ~(a | b);
            OP17_AND:  r = a & b;
            OP17_OR:   r = a | b;
            OP17_XOR:  r = a ^ b;
            OP17_SLLW, OP17_SLLIW: r = a << b[4:0];
            OP17_SRLW, OP17_SRLIW: r = a >> b[4:0];
            default: begin
                r = a >> b[4:0];
                if (a[31]) begin
                    r = r | ~(32'hffff_ffff >> b[4:0]);  // Fill vacated bits with the sign.
                end
            end
        endcase
        return r;
    endfunction

    // Drives one word for one cycle and queues the commit it must produce.
    task automatic issue(input word_t inst, input commit_t exp);
        inst_en_i = 1'b1;
        inst_i    = inst;
        pc_i      = cur_pc;
        expected.push_back(exp);
        if (exp.wr_en && !exp.exc && exp.rd != '0) begin
            model[exp.rd] = exp.data;
        end
        issued = issued + 1;
        cur_pc = cur_pc + 32'd4;
        @(negedge clk);
        inst_en_i = 1'b0;
    endtask

    // Commits are compared at the falling edge, half a cycle after they change.
    always @(negedge clk) begin
        if (!reset_i && commit_o.valid) begin
            if (expected.size() == 0) begin
                $display("A commit arrived with no instruction left to retire.");
                abort_run();
            end else begin
                check_commit(commit_o, expected.pop_front());
            end
        end
    end

    // Each instruction needs one issue cycle, and its drain at most three more.
    initial begin
        while ($time < 64'(issued) * 64'd40 + 64'd400) begin
            @(negedge clk);
        end
        $display("Timeout: the DUT stopped committing instructions.");
        abort_run();
    end

    initial begin
        seed      = 32'h6207;
        issued    = 0;
        cur_pc    = 32'h1c00_0000;
        model     = '{default: '0};
        clk       = 1'b0;
        reset_i   = 1'b1;
        inst_en_i = 1'b0;
        pc_i      = '0;
        inst_i    = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        test_reset_state();
        test_reg_ops();
        test_imm_ops();
        test_bypass_chain();
        test_exceptions();
        drain();

        $display("Test OK");
        $finish;
    end

endmodule

// File: src/core_top.sv
`timescale 1ns/10ps

module core_top (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              inst_en_i,
    input  isa_pkg::word_t    pc_i,
    input  isa_pkg::word_t    inst_i,
    output pipe_pkg::commit_t commit_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    decoded_t  dec;
    reg_addr_t rj_addr;
    reg_addr_t rk_addr;
    word_t     rj_data;
    word_t     rk_data;
    commit_t   cmt;

    decode_stage u_decode (
        .clk       (clk),
        .reset_i   (reset_i),
        .inst_en_i (inst_en_i),
        .pc_i      (pc_i),
        .inst_i    (inst_i),
        .dec_o     (dec)
    );

    execute_stage u_execute (
        .clk       (clk),
        .reset_i   (reset_i),
        .dec_i     (dec),
        .rj_addr_o (rj_addr),
        .rk_addr_o (rk_addr),
        .rj_data_i (rj_data),
        .rk_data_i (rk_data),
        .cmt_o     (cmt)
    );

    // The register file is written from the same record that leaves the core.
    result_stage u_result (
        .clk       (clk),
        .reset_i   (reset_i),
        .cmt_i     (cmt),
        .rj_addr_i (rj_addr),
        .rk_addr_i (rk_addr),
        .rj_data_o (rj_data),
        .rk_data_o (rk_data)
    );

    assign commit_o = cmt;

endmodule

// File: src/result_stage.sv
`timescale 1ns/10ps

module result_stage (
    input  logic               clk,
    input  logic               reset_i,
    input  pipe_pkg::commit_t  cmt_i,
    input  isa_pkg::reg_addr_t rj_addr_i,
    input  isa_pkg::reg_addr_t rk_addr_i,
    output isa_pkg::word_t     rj_data_o,
    output isa_pkg::word_t     rk_data_o
);

    import isa_pkg::*;

    word_t regs [REG_COUNT];
    logic  wr_en;

    assign wr_en = cmt_i.valid & cmt_i.wr_en & ~cmt_i.exc;

    // A read that hits the pending write sees the new value, so a dependent
    // instruction right behind its producer needs no stall.
    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_en && addr == cmt_i.rd) begin
            data = cmt_i.data;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rj_data_o = read_port(rj_addr_i);
        rk_data_o = read_port(rk_addr_i);
    end

    ////////////////////
    // Write port

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && cmt_i.rd != '0) begin  // r0 stays zero.
            regs[cmt_i.rd] <= cmt_i.data;
        end
    end

endmodule

// File: src/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
    input  logic               clk,
    input  logic               reset_i,
    input  pipe_pkg::decoded_t dec_i,
    output isa_pkg::reg_addr_t rj_addr_o,
    output isa_pkg::reg_addr_t rk_addr_o,
    input  isa_pkg::word_t     rj_data_i,
    input  isa_pkg::word_t     rk_data_i,
    output pipe_pkg::commit_t  cmt_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    word_t      op_a;
    word_t      op_b;
    logic [4:0] sa;
    word_t      arith_res;
    word_t      logic_res;
    word_t      shift_res;
    word_t      result;
    commit_t    cmt_d;
    commit_t    cmt_q;

    assign rj_addr_o = dec_i.rj;
    assign rk_addr_o = dec_i.rk;

    assign op_a = (dec_i.op == ALU_PCADDU12I) ? dec_i.pc : rj_data_i;
    assign op_b = dec_i.use_imm ? dec_i.imm : rk_data_i;
    assign sa   = op_b[4:0];  // Only the low 5 bits count as a shift amount.

    ////////////////////
    // ALU units

    always_comb begin
        case (dec_i.op)
            ALU_SUB:             arith_res = op_a - op_b;
            ALU_SLT, ALU_SLTI:   arith_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU, ALU_SLTUI: arith_res = {31'b0, op_a < op_b};
            default:             arith_res = op_a + op_b;
        endcase
    end

    always_comb begin
        case (dec_i.op)
            ALU_NOR:           logic_res = ~(op_a | op_b);
            ALU_AND, ALU_ANDI: logic_res = op_a & op_b;
            ALU_XOR, ALU_XORI: logic_res = op_a ^ op_b;
            default:           logic_res = op_a | op_b;  // OR, ORI and LU12I.W.
        endcase
    end

    always_comb begin
        case (dec_i.op)
            ALU_SRL, ALU_SRLI: shift_res = op_a >> sa;
            ALU_SRA, ALU_SRAI: shift_res = $signed(op_a) >>> sa;
            default:           shift_res = op_a << sa;
        endcase
    end

    always_comb begin
        case (dec_i.sel)
            SEL_ARITH: result = arith_res;
            SEL_LOGIC: result = logic_res;
            SEL_SHIFT: result = shift_res;
            default:   result = '0;
        endcase
    end

    ////////////////////
    // Commit record

    always_comb begin
        cmt_d.valid = dec_i.valid;
        cmt_d.exc   = dec_i.exc;
        cmt_d.cause = dec_i.cause;
        cmt_d.wr_en = dec_i.wr_en;
        cmt_d.rd    = dec_i.rd;
        cmt_d.data  = result;
    end

    always_ff @(posedge clk) begin
        cmt_q <= cmt_d;
        if (reset_i) begin
            cmt_q.valid <= 1'b0;
        end
    end

    assign cmt_o = cmt_q;

endmodule

// File: src/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               inst_en_i,
    input  isa_pkg::word_t     pc_i,
    input  isa_pkg::word_t     inst_i,
    output pipe_pkg::decoded_t dec_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    opcode10_t  op10;
    opcode17_t  op17;
    opcode7_t   op7;
    imm12_t     imm12;
    imm20_t     imm20;
    logic [4:0] shamt;
    reg_addr_t  rj;
    reg_addr_t  rk;
    reg_addr_t  rd;

    alu_op_e  op;
    decoded_t dec_d;
    decoded_t dec_q;

    assign op10  = inst_i[31:22];
    assign op17  = inst_i[31:15];
    assign op7   = inst_i[31:25];
    assign imm12 = inst_i[21:10];
    assign imm20 = inst_i[24:5];
    assign shamt = inst_i[14:10];
    assign rk    = inst_i[14:10];
    assign rj    = inst_i[9:5];
    assign rd    = inst_i[4:0];

    ////////////////////
    // Opcode match

    // The three field widths never hit on the same word.
    always_comb begin
        op = ALU_NOP;
        case (op10)
            OP10_SLTI:  op = ALU_SLTI;
            OP10_SLTUI: op = ALU_SLTUI;
            OP10_ADDIW: op = ALU_ADDI;
            OP10_ANDI:  op = ALU_ANDI;
            OP10_ORI:   op = ALU_ORI;
            OP10_XORI:  op = ALU_XORI;
            default: ;
        endcase
        case (op17)
            OP17_ADDW:    op = ALU_ADD;
            OP17_SUBW:    op = ALU_SUB;
            OP17_SLT:     op = ALU_SLT;
            OP17_SLTU:    op = ALU_SLTU;
            OP17_NOR:     op = ALU_NOR;
            OP17_AND:     op = ALU_AND;
            OP17_OR:      op = ALU_OR;
            OP17_XOR:     op = ALU_XOR;
            OP17_SLLW:    op = ALU_SLL;
            OP17_SRLW:    op = ALU_SRL;
            OP17_SRAW:    op = ALU_SRA;
            OP17_SLLIW:   op = ALU_SLLI;
            OP17_SRLIW:   op = ALU_SRLI;
            OP17_SRAIW:   op = ALU_SRAI;
            OP17_BREAK:   op = ALU_BREAK;
            OP17_SYSCALL: op = ALU_SYSCALL;
            default: ;
        endcase
        case (op7)
            OP7_LU12IW:    op = ALU_LU12I;
            OP7_PCADDU12I: op = ALU_PCADDU12I;
            default: ;
        endcase
    end

    ////////////////////
    // Operand and immediate form

    always_comb begin
        dec_d       = '0;
        dec_d.valid = inst_en_i;
        dec_d.pc    = pc_i;
        dec_d.op    = op;
        dec_d.rj    = rj;
        dec_d.rk    = rk;
        dec_d.rd    = rd;
        dec_d.wr_en = 1'b1;
        case (op)
            ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU: dec_d.sel = SEL_ARITH;
            ALU_NOR, ALU_AND, ALU_OR, ALU_XOR:   dec_d.sel = SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:           dec_d.sel = SEL_SHIFT;
            ALU_ADDI, ALU_SLTI, ALU_SLTUI: begin
                dec_d.sel     = SEL_ARITH;
                dec_d.use_imm = 1'b1;
                dec_d.imm     = {{20{imm12[11]}}, imm12};
            end
            ALU_ANDI, ALU_ORI, ALU_XORI: begin
                dec_d.sel     = SEL_LOGIC;
                dec_d.use_imm = 1'b1;
                dec_d.imm     = {20'b0, imm12};
            end
            ALU_SLLI, ALU_SRLI, ALU_SRAI: begin
                dec_d.sel     = SEL_SHIFT;
                dec_d.use_imm = 1'b1;
                dec_d.imm     = {27'b0, shamt};
            end
            ALU_PCADDU12I: begin
                dec_d.sel     = SEL_ARITH;
                dec_d.use_imm = 1'b1;
                dec_d.imm     = {imm20, 12'b0};
            end
            ALU_LU12I: begin
                dec_d.sel     = SEL_LOGIC;  // Computed as r0 | imm.
                dec_d.use_imm = 1'b1;
                dec_d.imm     = {imm20, 12'b0};
                dec_d.rj      = '0;
            end
            ALU_BREAK, ALU_SYSCALL: begin
                dec_d.wr_en = 1'b0;
                dec_d.exc   = 1'b1;
                dec_d.cause = (op == ALU_BREAK) ? EXC_BRK : EXC_SYS;
            end
            default: begin
                // No match. The all-zero word is a plain NOP.
                dec_d.wr_en = 1'b0;
                if (inst_i != '0) begin
                    dec_d.exc   = 1'b1;
                    dec_d.cause = EXC_INE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        dec_q <= dec_d;
        if (reset_i) begin
            dec_q.valid <= 1'b0;
        end
    end

    assign dec_o = dec_q;

endmodule

// File: src/pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [4:0] {
        ALU_NOP       = 5'd0,
        ALU_ADD       = 5'd1,
        ALU_SUB       = 5'd2,
        ALU_SLT       = 5'd3,
        ALU_SLTU      = 5'd4,
        ALU_NOR       = 5'd5,
        ALU_AND       = 5'd6,
        ALU_OR        = 5'd7,
        ALU_XOR       = 5'd8,
        ALU_SLL       = 5'd9,
        ALU_SRL       = 5'd10,
        ALU_SRA       = 5'd11,
        ALU_ADDI      = 5'd12,
        ALU_SLTI      = 5'd13,
        ALU_SLTUI     = 5'd14,
        ALU_ANDI      = 5'd15,
        ALU_ORI       = 5'd16,
        ALU_XORI      = 5'd17,
        ALU_SLLI      = 5'd18,
        ALU_SRLI      = 5'd19,
        ALU_SRAI      = 5'd20,
        ALU_LU12I     = 5'd21,
        ALU_PCADDU12I = 5'd22,
        ALU_BREAK     = 5'd23,
        ALU_SYSCALL   = 5'd24
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_NONE  = 2'd0,
        SEL_ARITH = 2'd1,
        SEL_LOGIC = 2'd2,
        SEL_SHIFT = 2'd3
    } alu_sel_e;

    typedef struct packed {
        logic                valid;
        isa_pkg::word_t      pc;
        alu_op_e             op;
        alu_sel_e            sel;
        isa_pkg::reg_addr_t  rj;
        isa_pkg::reg_addr_t  rk;
        logic                use_imm;   // Second operand is imm, not rk data.
        isa_pkg::word_t      imm;
        logic                wr_en;
        isa_pkg::reg_addr_t  rd;
        logic                exc;
        isa_pkg::exc_cause_t cause;
    } decoded_t;

    typedef struct packed {
        logic                valid;
        logic                exc;
        isa_pkg::exc_cause_t cause;
        logic                wr_en;
        isa_pkg::reg_addr_t  rd;
        isa_pkg::word_t      data;
    } commit_t;

endpackage

// File: src/isa_pkg.sv
package isa_pkg;

    ////////////////////
    // Word and field types.

    typedef logic [31:0] word_t;      // Data, pc or instruction word.
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] imm12_t;
    typedef logic [19:0] imm20_t;
    typedef logic [5:0]  exc_cause_t;

    typedef logic [9:0]  opcode10_t;  // Taken from inst[31:22].
    typedef logic [16:0] opcode17_t;  // Taken from inst[31:15].
    typedef logic [6:0]  opcode7_t;   // Taken from inst[31:25].

    localparam int REG_COUNT = 32;

    ////////////////////
    // Exception causes follow the ECODE field.

    localparam exc_cause_t EXC_SYS = 6'h0b;
    localparam exc_cause_t EXC_BRK = 6'h0c;
    localparam exc_cause_t EXC_INE = 6'h0d;

    ////////////////////
    // Opcodes.

    // Immediate forms with a 12-bit field in inst[21:10].
    localparam opcode10_t OP10_SLTI  = 10'h008;
    localparam opcode10_t OP10_SLTUI = 10'h009;
    localparam opcode10_t OP10_ADDIW = 10'h00a;
    localparam opcode10_t OP10_ANDI  = 10'h00d;
    localparam opcode10_t OP10_ORI   = 10'h00e;
    localparam opcode10_t OP10_XORI  = 10'h00f;

    // Three-register forms.
    localparam opcode17_t OP17_ADDW = 17'h00020;
    localparam opcode17_t OP17_SUBW = 17'h00022;
    localparam opcode17_t OP17_SLT  = 17'h00024;
    localparam opcode17_t OP17_SLTU = 17'h00025;
    localparam opcode17_t OP17_NOR  = 17'h00028;
    localparam opcode17_t OP17_AND  = 17'h00029;
    localparam opcode17_t OP17_OR   = 17'h0002a;
    localparam opcode17_t OP17_XOR  = 17'h0002b;
    localparam opcode17_t OP17_SLLW = 17'h0002e;
    localparam opcode17_t OP17_SRLW = 17'h0002f;
    localparam opcode17_t OP17_SRAW = 17'h00030;

    localparam opcode17_t OP17_BREAK   = 17'h00054;
    localparam opcode17_t OP17_SYSCALL = 17'h00056;

    // Shift by a 5-bit amount held in inst[14:10].
    localparam opcode17_t OP17_SLLIW = 17'h00081;
    localparam opcode17_t OP17_SRLIW = 17'h00089;
    localparam opcode17_t OP17_SRAIW = 17'h00091;

    // Upper-immediate forms hold a 20-bit field in inst[24:5].
    localparam opcode7_t OP7_LU12IW     = 7'h0a;
    localparam opcode7_t OP7_PCADDU12I  = 7'h0e;

endpackage
